// ==== list.f ====
pe_cfg_pkg.sv
pe_isa_pkg.sv
inst_mem.sv
control.sv
data_mem.sv
complex_alu.sv
pe.sv
pe_sva.sv
tb_pe.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       ?= tb_pe
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_pe.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pe
    import pe_cfg_pkg::*, pe_isa_pkg::*;
();

    // kinds of test round
    typedef enum int {
        kind_mov,
        kind_addsub,
        kind_mul,
        kind_chain,
        kind_end_halt,
        kind_end_full
    } round_kind_t;

    // per round: data load, program load, drain
    localparam int round_limit  = 20;
    localparam int round_cycles = reg_num + prog_depth + 30;
    localparam int cycle_limit  = round_limit * round_cycles;

    logic                      clk;
    logic                      rst;
    logic                      din_v;
    logic [word_width-1:0]     din_pe;
    logic                      inst_in_v;
    logic [inst_width-1:0]     inst_in;
    logic                      run;
    logic                      busy;
    logic                      dout_v;
    logic [word_width-1:0]     dout_pe;

    // stimulus and reference model state
    logic [31:0]               lfsr = 32'h2556;
    logic [word_width-1:0]     model_mem [0:reg_num-1];
    logic [inst_width-1:0]     prog [0:prog_depth-1];
    logic [reg_addr_width-1:0] dst_hist [0:prog_depth-1];
    int                        prog_len;
    logic [word_width-1:0]     exp_q [$];
    logic [word_width-1:0]     exp_word;
    int                        exp_count = 0;
    int                        out_count = 0;
    int                        cycle_count = 0;

    pe pe_i (
        .clk       (clk),
        .rst       (rst),
        .din_v     (din_v),
        .din_pe    (din_pe),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .run       (run),
        .busy      (busy),
        .dout_v    (dout_v),
        .dout_pe   (dout_pe)
    );

    bind pe pe_sva pe_sva_i (
        .clk       (clk),
        .rst       (rst),
        .din_v     (din_v),
        .inst_in_v (inst_in_v),
        .run       (run),
        .busy      (busy),
        .dout_v    (dout_v)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // near_limit mixes in values at the edges of the 16-bit range
    function automatic logic [data_width-1:0] random_half(input logic near_limit);
        logic [31:0] r;
        logic [31:0] pick;
        r = random_bits(data_width);
        if (near_limit) begin
            pick = random_bits(3);
            case (pick[2:0])
                3'd0: r = 32'h7fff;
                3'd1: r = 32'h8000;
                3'd2: r = 32'h7ffe;
                3'd3: r = 32'h8001;
                default: ;
            endcase
        end
        return r[data_width-1:0];
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // q1.15 complex ops, halves wrap at 16 bits
    function automatic logic [word_width-1:0] alu_model(input opcode_t op,
                                                         input logic [word_width-1:0] a,
                                                         input logic [word_width-1:0] b);
        longint                ar, ai, br, bi, re, im;
        logic [data_width-1:0] hr;
        logic [data_width-1:0] hi;
        ar = longint'($signed(a[31:16]));
        ai = longint'($signed(a[15:0]));
        br = longint'($signed(b[31:16]));
        bi = longint'($signed(b[15:0]));
        case (op)
            op_add: begin
                hr = a[31:16] + b[31:16];
                hi = a[15:0] + b[15:0];
            end
            op_sub: begin
                hr = a[31:16] - b[31:16];
                hi = a[15:0] - b[15:0];
            end
            op_mul: begin
                // arithmetic shift by 15, keep the low 16 bits
                re = (ar * br - ai * bi) >>> frac_bits;
                im = (ar * bi + ai * br) >>> frac_bits;
                hr = re[15:0];
                hi = im[15:0];
            end
            default: begin
                hr = a[31:16];
                hi = a[15:0];
            end
        endcase
        return {hr, hi};
    endfunction

    // addr written by one of the four instructions before j
    function automatic logic in_window(input logic [reg_addr_width-1:0] addr, input int j);
        logic hit;
        hit = 1'b0;
        for (int k = (j > 4) ? j - 4 : 0; k < j; k++) begin
            if (dst_hist[k] == addr) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic [reg_addr_width-1:0] pick_source(input int j);
        logic [31:0] r;
        do begin
            r = random_bits(reg_addr_width);
        end while (in_window(r[4:0], j));
        return r[4:0];
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    task automatic load_data(input round_kind_t kind);
        logic near_limit;
        near_limit = (kind == kind_addsub) || (kind == kind_mul);
        for (int i = 0; i < reg_num; i++) begin
            din_pe = {random_half(near_limit), random_half(near_limit)};
            // -1.0 + 0i at address 0 for the -1 * -1 case
            if (kind == kind_mul && i == 0) begin
                din_pe = 32'h8000_0000;
            end
            model_mem[i] = din_pe;
            din_v = 1'b1;
            next_cycle();
        end
        din_v = 1'b0;
    endtask

    task automatic build_program(input round_kind_t kind, input int base);
        logic [31:0]               r;
        opcode_t                   op;
        logic                      out_flag;
        logic [reg_addr_width-1:0] dst;
        logic [reg_addr_width-1:0] s0;
        logic [reg_addr_width-1:0] s1;
        prog_len = prog_depth;
        if (kind == kind_end_halt) begin
            r = random_bits(4);
            prog_len = 1 + int'(r[3:0]) % (prog_depth - 1);
        end
        for (int j = 0; j < prog_len; j++) begin
            r = random_bits(8);
            out_flag = 1'b1;
            dst = r[4:0];
            s0 = pick_source(j);
            s1 = pick_source(j);
            case (kind)
                kind_mov: begin
                    op = op_mov;
                    s0 = 5'(base + j);
                    dst = s0;
                end
                kind_addsub: begin
                    op = r[5] ? op_sub : op_add;
                end
                kind_mul: begin
                    op = op_mul;
                    if (j == 0) begin
                        s0 = '0;
                        s1 = '0;
                    end
                end
                default: begin
                    // add, sub, mul or mov
                    op = opcode_t'({1'b0, r[6:5]} + 3'd1);
                    out_flag = r[7] || (j == prog_len - 1);
                    // reuse the result of five instructions back
                    if (kind == kind_chain && j >= 5 && !in_window(dst_hist[j-5], j)) begin
                        s0 = dst_hist[j-5];
                    end
                end
            endcase
            prog[j]     = {op, out_flag, dst, s0, s1};
            dst_hist[j] = dst;
        end
    endtask

    // halt after a short program so stale entries never issue
    task automatic load_program();
        for (int j = 0; j < prog_depth; j++) begin
            if (j <= prog_len) begin
                inst_in_v = 1'b1;
                inst_in   = (j < prog_len) ? prog[j] : '0;
                next_cycle();
            end
        end
        inst_in_v = 1'b0;
    endtask

    // program order, flagged results queued
    task automatic model_program();
        logic [inst_width-1:0] inst;
        logic [word_width-1:0] res;
        for (int j = 0; j < prog_len; j++) begin
            inst = prog[j];
            res  = alu_model(opcode_t'(inst[op_msb:op_lsb]), model_mem[inst[src0_msb:src0_lsb]],
                             model_mem[inst[src1_msb:src1_lsb]]);
            model_mem[inst[dst_msb:dst_lsb]] = res;
            if (inst[out_bit]) begin
                exp_q.push_back(res);
                exp_count++;
            end
        end
    endtask

    task automatic run_round(input round_kind_t kind, input int base, input logic reset_mid);
        logic [31:0] r;
        int          wait_cycles;
        load_data(kind);
        build_program(kind, base);
        load_program();
        model_program();
        run = 1'b1;
        next_cycle();
        run = 1'b0;
        assert (busy === 1'b1)
            else stop_on_error($sformatf("Error: busy expected %h got %h", 1'b1, busy));
        if (reset_mid) begin
            r = random_bits(3);
            wait_cycles = 4 + int'(r[2:0]);
            repeat (wait_cycles) next_cycle();
            // pending results are lost
            rst = 1'b1;
            exp_count = exp_count - exp_q.size();
            exp_q.delete();
            repeat (3) next_cycle();
            assert (busy === 1'b0)
                else stop_on_error($sformatf("Error: busy expected %h got %h", 1'b0, busy));
            assert (dout_v === 1'b0)
                else stop_on_error($sformatf("Error: dout_v expected %h got %h", 1'b0, dout_v));
            rst = 1'b0;
        end else begin
            while (busy) begin
                next_cycle();
            end
            assert (exp_q.size() == 0)
                else stop_on_error($sformatf("%0d flagged results never came out before busy fell",
                                             exp_q.size()));
        end
    endtask

    ////////////////////
    // checks
    ////////////////////

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        assert (cycle_count <= cycle_limit)
            else stop_on_error("the run went past its cycle limit without finishing");
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            assert (!dout_v || busy)
                else stop_on_error("dout_v pulsed while busy was low");
            if (dout_v) begin
                assert (exp_q.size() > 0)
                    else stop_on_error("dout_v pulsed with no result expected");
                exp_word = exp_q.pop_front();
                assert (dout_pe === exp_word)
                    else stop_on_error($sformatf("Error: dout_pe expected %h got %h",
                                                 exp_word, dout_pe));
                out_count++;
            end
        end
    end

    initial begin
        rst       = 1'b1;
        din_v     = 1'b0;
        din_pe    = '0;
        inst_in_v = 1'b0;
        inst_in   = '0;
        run       = 1'b0;
        repeat (3) next_cycle();
        rst = 1'b0;
        // every address as src0 over two mov rounds
        run_round(kind_mov, 0, 1'b0);
        run_round(kind_mov, 16, 1'b0);
        repeat (3) run_round(kind_addsub, 0, 1'b0);
        repeat (3) run_round(kind_mul, 0, 1'b0);
        repeat (3) run_round(kind_chain, 0, 1'b0);
        repeat (2) run_round(kind_end_halt, 0, 1'b0);
        run_round(kind_end_full, 0, 1'b0);
        // reset in the middle, then a clean load and run
        run_round(kind_chain, 0, 1'b1);
        run_round(kind_mov, 0, 1'b0);
        run_round(kind_mov, 16, 1'b0);
        repeat (4) next_cycle();
        if (exp_q.size() == 0 && out_count == exp_count) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "expected and observed result counts differ");
        end
    end

endmodule

`default_nettype wire

// ==== pe_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module pe_sva (
    input wire logic clk,
    input wire logic rst,
    input wire logic din_v,
    input wire logic inst_in_v,
    input wire logic run,
    input wire logic busy,
    input wire logic dout_v
);

    ////////////////////
    // host protocol
    ////////////////////

    // no loads and no new run while a program is in flight
    host_quiet_while_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !(din_v || inst_in_v || run)
    ) else $error("load strobe or run asserted while busy");

    ////////////////////
    // pipeline
    ////////////////////

    // results only leave while busy
    dout_only_when_busy: assert property (
        @(posedge clk) disable iff (rst) dout_v |-> busy
    ) else $error("dout_v high while busy low");

    // reset clears the issue and writeback stages
    idle_after_reset: assert property (
        @(posedge clk) rst |=> !busy
    ) else $error("busy high in the cycle after reset");

endmodule

`default_nettype wire

// ==== pe.sv ====
`timescale 1ns/1ns
`default_nettype none

module pe
    import pe_cfg_pkg::*, pe_isa_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  din_v,
    input  wire logic [word_width-1:0] din_pe,
    input  wire logic                  inst_in_v,
    input  wire logic [inst_width-1:0] inst_in,
    input  wire logic                  run,
    output logic                       busy,
    output logic                       dout_v,
    output logic      [word_width-1:0] dout_pe
);

    // issue path
    logic                      issue_v;
    logic [inst_width-1:0]     issue_inst;
    logic                      fetching;
    // memory ports
    logic [reg_addr_width-1:0] rd_addr0;
    logic [reg_addr_width-1:0] rd_addr1;
    logic [word_width-1:0]     rdata0;
    logic [word_width-1:0]     rdata1;
    logic                      wr_en;
    logic [reg_addr_width-1:0] wr_addr;
    logic [word_width-1:0]     wr_data;
    // alu
    opcode_t                   alu_op;
    logic [word_width-1:0]     alu_result;

    ////////////////////
    // blocks
    ////////////////////

    // program storage and pc
    inst_mem inst_mem_i (
        .clk        (clk),
        .rst        (rst),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .run        (run),
        .issue_v    (issue_v),
        .issue_inst (issue_inst),
        .fetching   (fetching)
    );

    // decode, load addressing and writeback
    control control_i (
        .clk        (clk),
        .rst        (rst),
        .din_v      (din_v),
        .din_pe     (din_pe),
        .run        (run),
        .fetching   (fetching),
        .issue_v    (issue_v),
        .issue_inst (issue_inst),
        .alu_result (alu_result),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .alu_op     (alu_op),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .dout_v     (dout_v),
        .dout_pe    (dout_pe)
    );

    data_mem data_mem_i (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr0 (rd_addr0),
        .rd_addr1 (rd_addr1),
        .rdata0   (rdata0),
        .rdata1   (rdata1)
    );

    // two cycles from rdata to alu_result
    complex_alu complex_alu_i (
        .clk    (clk),
        .rst    (rst),
        .alu_op (alu_op),
        .din_1  (rdata0),
        .din_2  (rdata1),
        .dout   (alu_result)
    );

endmodule

`default_nettype wire

// ==== complex_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module complex_alu
    import pe_cfg_pkg::*, pe_isa_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire opcode_t               alu_op,
    input  wire logic [word_width-1:0] din_1,
    input  wire logic [word_width-1:0] din_2,
    output logic      [word_width-1:0] dout
);

    // operand halves
    logic signed [data_width-1:0]   ar;
    logic signed [data_width-1:0]   ai;
    logic signed [data_width-1:0]   br;
    logic signed [data_width-1:0]   bi;
    // stage one
    opcode_t                        op_q;
    logic signed [2*data_width-1:0] p_rr;
    logic signed [2*data_width-1:0] p_ii;
    logic signed [2*data_width-1:0] p_ri;
    logic signed [2*data_width-1:0] p_ir;
    logic        [data_width-1:0]   s1_re;
    logic        [data_width-1:0]   s1_im;
    // stage two sums, one extra bit so -1 * -1 does not overflow here
    logic signed [2*data_width:0]   acc_re;
    logic signed [2*data_width:0]   acc_im;

    assign ar = din_1[word_width-1:data_width];
    assign ai = din_1[data_width-1:0];
    assign br = din_2[word_width-1:data_width];
    assign bi = din_2[data_width-1:0];

    ////////////////////
    // stage one
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= op_halt;
        end else begin
            op_q <= alu_op;
        end
    end

    // partial products are formed for every op, only mul uses them
    always_ff @(posedge clk) begin
        p_rr <= ar * br;
        p_ii <= ai * bi;
        p_ri <= ar * bi;
        p_ir <= ai * br;
        case (alu_op)
            // add and sub wrap at 16 bits per half
            op_add: begin
                s1_re <= ar + br;
                s1_im <= ai + bi;
            end
            op_sub: begin
                s1_re <= ar - br;
                s1_im <= ai - bi;
            end
            // mov passes din_1
            default: begin
                s1_re <= ar;
                s1_im <= ai;
            end
        endcase
    end

    ////////////////////
    // stage two
    ////////////////////

    assign acc_re = p_rr - p_ii;
    assign acc_im = p_ri + p_ir;

    // picking bits [30:15] is an arithmetic shift by 15 then truncation
    always_ff @(posedge clk) begin
        if (op_q == op_mul) begin
            dout <= {acc_re[frac_bits+data_width-1:frac_bits],
                     acc_im[frac_bits+data_width-1:frac_bits]};
        end else begin
            dout <= {s1_re, s1_im};
        end
    end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem
    import pe_cfg_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      wr_en,
    input  wire logic [reg_addr_width-1:0] wr_addr,
    input  wire logic [word_width-1:0]     wr_data,
    input  wire logic [reg_addr_width-1:0] rd_addr0,
    input  wire logic [reg_addr_width-1:0] rd_addr1,
    output logic      [word_width-1:0]     rdata0,
    output logic      [word_width-1:0]     rdata1
);

    // 32 complex words, {re, im}
    logic [word_width-1:0] mem [0:reg_num-1];

    ////////////////////
    // write port
    ////////////////////

    // one write per cycle, loads and writebacks share it
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // both reads registered every cycle
    // same-address write in this cycle still returns the old word
    always_ff @(posedge clk) begin
        rdata0 <= mem[rd_addr0];
        rdata1 <= mem[rd_addr1];
    end

endmodule

`default_nettype wire

// ==== control.sv ====
`timescale 1ns/1ns
`default_nettype none

module control
    import pe_cfg_pkg::*, pe_isa_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      din_v,
    input  wire logic [word_width-1:0]     din_pe,
    input  wire logic                      run,
    input  wire logic                      fetching,
    input  wire logic                      issue_v,
    input  wire logic [inst_width-1:0]     issue_inst,
    input  wire logic [word_width-1:0]     alu_result,
    output logic      [reg_addr_width-1:0] rd_addr0,
    output logic      [reg_addr_width-1:0] rd_addr1,
    output opcode_t                        alu_op,
    output logic                           wr_en,
    output logic      [reg_addr_width-1:0] wr_addr,
    output logic      [word_width-1:0]     wr_data,
    output logic                           busy,
    output logic                           dout_v,
    output logic      [word_width-1:0]     dout_pe
);

    logic [reg_addr_width-1:0] load_ptr;
    logic [alu_latency:0]      v_pipe;
    logic [alu_latency:0]      out_pipe;
    logic [reg_addr_width-1:0] dst_pipe [0:alu_latency];
    logic                      wb_v;
    logic                      wb_out;
    logic [reg_addr_width-1:0] wb_dst;
    logic [word_width-1:0]     wb_data;

    ////////////////////
    // decode
    ////////////////////

    // read addresses go straight to the memory, data comes back next cycle
    assign rd_addr0 = issue_inst[src0_msb:src0_lsb];
    assign rd_addr1 = issue_inst[src1_msb:src1_lsb];

    // opcode delayed one cycle to line up with rdata0/rdata1
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_op <= op_halt;
        end else begin
            alu_op <= opcode_t'(issue_inst[op_msb:op_lsb]);
        end
    end

    ////////////////////
    // delay line
    ////////////////////

    // one stage for the memory read plus the alu stages
    always_ff @(posedge clk) begin
        if (rst) begin
            v_pipe <= '0;
            wb_v   <= 1'b0;
        end else begin
            v_pipe <= {v_pipe[alu_latency-1:0], issue_v};
            wb_v   <= v_pipe[alu_latency];
        end
    end

    // dst and out flag only matter while the matching valid bit is set
    always_ff @(posedge clk) begin
        out_pipe    <= {out_pipe[alu_latency-1:0], issue_inst[out_bit]};
        dst_pipe[0] <= issue_inst[dst_msb:dst_lsb];
        for (int i = 1; i <= alu_latency; i++) begin
            dst_pipe[i] <= dst_pipe[i-1];
        end
        wb_out  <= out_pipe[alu_latency];
        wb_dst  <= dst_pipe[alu_latency];
        wb_data <= alu_result;
    end

    ////////////////////
    // write port
    ////////////////////

    // data load pointer wraps at reg_num
    always_ff @(posedge clk) begin
        if (rst || run) begin
            load_ptr <= '0;
        end else if (din_v) begin
            load_ptr <= load_ptr + reg_addr_width'(1);
        end
    end

    // writeback wins, host loads never overlap a run
    assign wr_en   = wb_v || din_v;
    assign wr_addr = wb_v ? wb_dst : load_ptr;
    assign wr_data = wb_v ? wb_data : din_pe;

    // busy until the last issued instruction writes back
    assign busy    = fetching || issue_v || (|v_pipe) || wb_v;
    assign dout_v  = wb_v && wb_out;
    assign dout_pe = wb_data;

endmodule

`default_nettype wire

// ==== inst_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_mem
    import pe_cfg_pkg::*, pe_isa_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  inst_in_v,
    input  wire logic [inst_width-1:0] inst_in,
    input  wire logic                  run,
    output logic                       issue_v,
    output logic [inst_width-1:0]      issue_inst,
    output logic                       fetching
);

    logic [inst_width-1:0] imem [0:prog_depth-1];
    logic [pc_width-1:0]   load_ptr;
    logic [pc_width-1:0]   pc;
    logic [pc_width-1:0]   fetch_pc;
    logic [inst_width-1:0] fetch_inst;
    logic                  fetch_now;
    logic                  fetch_halt;

    ////////////////////
    // program load
    ////////////////////

    always_ff @(posedge clk) begin
        if (inst_in_v) begin
            imem[load_ptr] <= inst_in;
        end
    end

    // pointer restarts at 0 on reset and on every run pulse
    always_ff @(posedge clk) begin
        if (rst || run) begin
            load_ptr <= '0;
        end else if (inst_in_v) begin
            load_ptr <= load_ptr + pc_width'(1);
        end
    end

    ////////////////////
    // fetch and issue
    ////////////////////

    // run fetches entry 0 in the same cycle, so issue starts one cycle later
    assign fetch_now  = run || fetching;
    assign fetch_pc   = run ? '0 : pc;
    assign fetch_inst = imem[fetch_pc];
    assign fetch_halt = (opcode_t'(fetch_inst[op_msb:op_lsb]) == op_halt);

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_v  <= 1'b0;
            fetching <= 1'b0;
            pc       <= '0;
        end else if (fetch_now) begin
            // halt itself is never issued
            issue_v  <= !fetch_halt;
            // last entry ends the program as well
            fetching <= !fetch_halt && (fetch_pc != pc_width'(prog_depth - 1));
            pc       <= fetch_pc + pc_width'(1);
        end else begin
            issue_v <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_now) begin
            issue_inst <= fetch_inst;
        end
    end

endmodule

`default_nettype wire

// ==== pe_isa_pkg.sv ====
`default_nettype none

package pe_isa_pkg;

    // instruction layout, msb first
    // [18:16] opcode  [15] out  [14:10] dst  [9:5] src0  [4:0] src1
    localparam int inst_width = 19;

    ////////////////////
    // opcodes
    ////////////////////

    // halt is zero so an unloaded entry stops the program
    typedef enum logic [2:0] {
        op_halt = 3'd0,
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_mul  = 3'd3,
        op_mov  = 3'd4
    } opcode_t;

    ////////////////////
    // field positions
    ////////////////////

    localparam int op_msb   = 18;
    localparam int op_lsb   = 16;
    localparam int out_bit  = 15;
    localparam int dst_msb  = 14;
    localparam int dst_lsb  = 10;
    localparam int src0_msb = 9;
    localparam int src0_lsb = 5;
    localparam int src1_msb = 4;
    localparam int src1_lsb = 0;

    // operands in to result out of the complex alu
    localparam int alu_latency = 2;

endpackage

`default_nettype wire

// ==== pe_cfg_pkg.sv ====
`default_nettype none

package pe_cfg_pkg;

    ////////////////////
    // data words
    ////////////////////

    // one half of a complex word, q1.15
    localparam int data_width = 16;
    // real in the upper half, imaginary in the lower half
    localparam int word_width = 2 * data_width;
    // fraction bits, used to scale products back to q1.15
    localparam int frac_bits = 15;

    ////////////////////
    // memories
    ////////////////////

    localparam int reg_num        = 32;
    localparam int reg_addr_width = 5;
    localparam int prog_depth     = 16;
    localparam int pc_width       = 4;

endpackage

`default_nettype wire
